// ==== verilog/ctrl_defines.svh ====
// controller field widths
// sizes of the pc source select, the forwarding selects, the jump kind
// and the controller state, shared by the type package
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// pc source select toward the fetch stage
`define CTRL_PC_MUX_W 3

// one operand forwarding select
`define CTRL_FW_SEL_W 2

// jump kind code from the decoder
`define CTRL_JUMP_W 2

// main fsm state register
`define CTRL_STATE_W 3

`endif

// ==== verilog/ctrl_pkg.sv ====
// controller type package
// enum types for pc source, operand forwarding, jump kind and fsm state
`default_nettype none

`include "ctrl_defines.svh"

package ctrl_pkg;

  // next pc source seen by the prefetcher
  // value 1 is left free, it belongs to a path this core does not use
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT      = 'd0,
    PC_JUMP      = 'd2,
    PC_BRANCH    = 'd3,
    PC_EXCEPTION = 'd4
  } pc_mux_e;

  // operand source in the id stage
  typedef enum logic [`CTRL_FW_SEL_W-1:0] {
    SEL_REGFILE = 'd0,
    SEL_FW_EX   = 'd1,
    SEL_FW_WB   = 'd2
  } fw_sel_e;

  // kind of control transfer found by the decoder
  typedef enum logic [`CTRL_JUMP_W-1:0] {
    BRANCH_NONE = 'd0,
    BRANCH_JAL  = 'd1,
    BRANCH_JALR = 'd2,
    BRANCH_COND = 'd3
  } jump_e;

  // main controller states, in encoding order
  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/ctrl_fsm.sv ====
// main control state machine
// steps the core from reset through boot and decode, redirects the pc for
// jumps, taken branches and exceptions, and flushes the pipe before sleep
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // core enable and decoder requests
  input  logic        fetch_enable_i,
  input  logic        pipe_flush_i,
  input  jump_e       jump_in_dec_i,

  // pipeline status
  input  logic        instr_valid_i,
  input  logic        id_ready_i,
  input  logic        ex_valid_i,
  input  logic        branch_taken_ex_i,
  input  logic        exc_req_i,
  input  logic        jr_stall_i,

  // status toward the core
  output logic        ctrl_busy_o,
  output logic        is_decoding_o,

  // prefetcher control
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_mux_e     pc_mux_o,

  // exception controller handshake
  output logic        exc_ack_o,
  output logic        exc_save_if_o,
  output logic        exc_save_id_o,

  // stage halts
  output logic        halt_if_o,
  output logic        halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump has redirected the pc, held until id accepts
  logic        jump_done_q;
  logic        jump_done_d;

  // unconditional jump sitting in decode
  logic        is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    // fetching and busy unless a state says otherwise
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_mux_o      = PC_BOOT;
    pc_set_o      = 1'b0;
    exc_ack_o     = 1'b0;
    exc_save_if_o = 1'b0;
    exc_save_id_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    jump_done_d   = jump_done_q;
    state_d       = state_q;

    case (state_q)
      // idle after reset until the core is enabled
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch pc
      BOOT_SET:
      begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // pipe is empty, wait for enable or an interrupt
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;

        // nothing in id yet, so the fetch pc is what gets saved
        if (exc_req_i)
        begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE:
      begin
        // only decode when no taken branch in ex is about to squash id
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (is_jump)
          begin
            pc_mux_o = PC_JUMP;
            // target known in id; redirect once, after a jalr operand is ready
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_mux_o      = PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            // keep the trapping instruction out of ex
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // wfi style flush, drain ex and wb first
          if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // taken branch in ex wins over anything decoded this cycle
        if (branch_taken_ex_i)
        begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
        end
      end

      // hold if and id while ex finishes
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // one more cycle for wb, then resume or sleep
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end
        else
          state_d = SLEEP;
      end

      // unused encoding, recover through reset
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and jump latch registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // id took the jump, so the next one may redirect again
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
// hazard detection
// load-use and jump-register stalls, and write-enable suppression for
// instructions that must not retire
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import ctrl_pkg::*;
(
  input  logic  is_decoding_i,
  input  logic  illegal_insn_i,
  input  logic  data_req_ex_i,
  input  logic  regfile_we_ex_i,
  input  logic  regfile_we_wb_i,
  input  logic  regfile_alu_we_fw_i,
  input  jump_e jump_in_dec_i,

  // destination of ex, wb and alu path matches source a, b or c
  input  logic  reg_d_ex_is_reg_a_i,
  input  logic  reg_d_ex_is_reg_b_i,
  input  logic  reg_d_ex_is_reg_c_i,
  input  logic  reg_d_wb_is_reg_a_i,
  input  logic  reg_d_wb_is_reg_b_i,
  input  logic  reg_d_wb_is_reg_c_i,
  input  logic  reg_d_alu_is_reg_a_i,
  input  logic  reg_d_alu_is_reg_b_i,
  input  logic  reg_d_alu_is_reg_c_i,

  output logic  load_stall_o,
  output logic  jr_stall_o,
  output logic  deassert_we_o
);

  // load in ex whose data arrives too late for forwarding
  logic ex_load;

  assign ex_load = data_req_ex_i & regfile_we_ex_i;

  assign load_stall_o = ex_load &
                        (reg_d_ex_is_reg_a_i | reg_d_ex_is_reg_b_i | reg_d_ex_is_reg_c_i);

  // jalr target must come from the register file, never from a forward
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) &
                      ((regfile_we_wb_i & reg_d_wb_is_reg_a_i) |
                       (regfile_we_ex_i & reg_d_ex_is_reg_a_i) |
                       (regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i));

  // whatever sits in id without being decoded must not write back
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

`default_nettype wire

// ==== verilog/fwd_unit.sv ====
// operand forwarding select
// picks register file, ex or wb data for operands a, b and c;
// a misaligned access takes over a and b for its second half
`timescale 1ns/1ps
`default_nettype none

module fwd_unit
  import ctrl_pkg::*;
(
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,
  input  logic    data_misaligned_i,

  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_wb_is_reg_c_i,
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_c_i,

  output fw_sel_e operand_a_fw_mux_sel_o,
  output fw_sel_e operand_b_fw_mux_sel_o,
  output fw_sel_e operand_c_fw_mux_sel_o
);

  // younger ex result beats the older wb result
  function automatic fw_sel_e operand_src(input logic wb_hit, input logic alu_hit);
    fw_sel_e src;
    src = SEL_REGFILE;
    if (wb_hit)
      src = SEL_FW_WB;
    if (alu_hit)
      src = SEL_FW_EX;
    return src;
  endfunction

  always_comb
  begin
    operand_a_fw_mux_sel_o = operand_src(regfile_we_wb_i & reg_d_wb_is_reg_a_i,
                                         regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i);
    operand_b_fw_mux_sel_o = operand_src(regfile_we_wb_i & reg_d_wb_is_reg_b_i,
                                         regfile_alu_we_fw_i & reg_d_alu_is_reg_b_i);
    operand_c_fw_mux_sel_o = operand_src(regfile_we_wb_i & reg_d_wb_is_reg_c_i,
                                         regfile_alu_we_fw_i & reg_d_alu_is_reg_c_i);

    // second half of a misaligned access reuses the ex address
    if (data_misaligned_i)
    begin
      operand_a_fw_mux_sel_o = SEL_FW_EX;
      operand_b_fw_mux_sel_o = SEL_REGFILE;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/core_controller.sv ====
// core controller top
// ties the control fsm, the hazard unit and the forwarding unit together
`timescale 1ns/1ps
`default_nettype none

module core_controller
  import ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    fetch_enable_i,
  input  logic    illegal_insn_i,
  input  logic    pipe_flush_i,
  input  logic    instr_valid_i,
  input  logic    id_ready_i,
  input  logic    ex_valid_i,
  input  logic    data_req_ex_i,
  input  logic    data_misaligned_i,
  input  logic    branch_taken_ex_i,
  input  logic    exc_req_i,
  input  logic    regfile_we_ex_i,
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,
  input  jump_e   jump_in_dec_i,

  // register match flags from the id stage
  input  logic    reg_d_ex_is_reg_a_i,
  input  logic    reg_d_ex_is_reg_b_i,
  input  logic    reg_d_ex_is_reg_c_i,
  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_wb_is_reg_c_i,
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_c_i,

  output logic    ctrl_busy_o,
  output logic    is_decoding_o,
  output logic    instr_req_o,
  output logic    pc_set_o,
  output pc_mux_e pc_mux_o,
  output logic    exc_ack_o,
  output logic    exc_save_if_o,
  output logic    exc_save_id_o,
  output logic    halt_if_o,
  output logic    halt_id_o,
  output logic    deassert_we_o,
  output logic    load_stall_o,
  output logic    jr_stall_o,
  output logic    misaligned_stall_o,
  output fw_sel_e operand_a_fw_mux_sel_o,
  output fw_sel_e operand_b_fw_mux_sel_o,
  output fw_sel_e operand_c_fw_mux_sel_o
);

  // decode status into the hazard unit, jalr stall back into the fsm
  logic is_decoding;
  logic jr_stall;

  ctrl_fsm ctrl_fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .pipe_flush_i      (pipe_flush_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .jr_stall_i        (jr_stall),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .exc_save_if_o     (exc_save_if_o),
    .exc_save_id_o     (exc_save_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  hazard_unit hazard_unit_i (
    .is_decoding_i        (is_decoding),
    .illegal_insn_i       (illegal_insn_i),
    .data_req_ex_i        (data_req_ex_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .reg_d_ex_is_reg_a_i  (reg_d_ex_is_reg_a_i),
    .reg_d_ex_is_reg_b_i  (reg_d_ex_is_reg_b_i),
    .reg_d_ex_is_reg_c_i  (reg_d_ex_is_reg_c_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i  (reg_d_wb_is_reg_b_i),
    .reg_d_wb_is_reg_c_i  (reg_d_wb_is_reg_c_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i (reg_d_alu_is_reg_b_i),
    .reg_d_alu_is_reg_c_i (reg_d_alu_is_reg_c_i),
    .load_stall_o         (load_stall_o),
    .jr_stall_o           (jr_stall),
    .deassert_we_o        (deassert_we_o)
  );

  fwd_unit fwd_unit_i (
    .regfile_we_wb_i        (regfile_we_wb_i),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_i),
    .data_misaligned_i      (data_misaligned_i),
    .reg_d_wb_is_reg_a_i    (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i    (reg_d_wb_is_reg_b_i),
    .reg_d_wb_is_reg_c_i    (reg_d_wb_is_reg_c_i),
    .reg_d_alu_is_reg_a_i   (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i   (reg_d_alu_is_reg_b_i),
    .reg_d_alu_is_reg_c_i   (reg_d_alu_is_reg_c_i),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o),
    .operand_c_fw_mux_sel_o (operand_c_fw_mux_sel_o)
  );

  assign is_decoding_o = is_decoding;
  assign jr_stall_o    = jr_stall;

  // lsu needs a second cycle for a misaligned access
  assign misaligned_stall_o = data_misaligned_i;

endmodule

`default_nettype wire

// ==== verif/ctrl_checker.sv ====
// controller output checker
// samples the controller outputs at the falling clock edge and compares
// them with the expected values of the current stimulus line
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module ctrl_checker (
  input  logic                      clk,
  input  logic                      check_en_i,

  // expected values from the stimulus line
  input  logic [12:0]               exp_status_i,
  input  logic [`CTRL_PC_MUX_W-1:0] exp_pc_mux_i,
  input  logic [11:0]               exp_sel_i,

  // controller outputs, packed in the same order
  input  logic [12:0]               act_status_i,
  input  logic [`CTRL_PC_MUX_W-1:0] act_pc_mux_i,
  input  logic [11:0]               act_sel_i,

  output int                        error_count_o,
  output int                        check_count_o
);

  int errors = 0;
  int checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  initial
    $timeformat(-9, 0, " ns", 0);

  // status bit 12 is ctrl_busy_o, bit 0 is misaligned_stall_o
  function automatic string status_name(input int idx);
    case (idx)
      12:      return "ctrl_busy_o";
      11:      return "is_decoding_o";
      10:      return "instr_req_o";
      9:       return "pc_set_o";
      8:       return "exc_ack_o";
      7:       return "exc_save_if_o";
      6:       return "exc_save_id_o";
      5:       return "halt_if_o";
      4:       return "halt_id_o";
      3:       return "deassert_we_o";
      2:       return "load_stall_o";
      1:       return "jr_stall_o";
      default: return "misaligned_stall_o";
    endcase
  endfunction

  task automatic compare_field(input string name, input logic [3:0] exp,
                               input logic [3:0] act);
    if (exp !== act)
    begin
      $display("Error at %t: %s expected %0h, actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // falling edge compare, inputs changed half a cycle before
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (check_en_i)
    begin
      checks++;
      for (int i = 12; i >= 0; i--)
        compare_field(status_name(i), {3'b000, exp_status_i[i]}, {3'b000, act_status_i[i]});
      compare_field("pc_mux_o", 4'(exp_pc_mux_i), 4'(act_pc_mux_i));
      // one hex digit per operand select
      compare_field("operand_a_fw_mux_sel_o", exp_sel_i[11:8], act_sel_i[11:8]);
      compare_field("operand_b_fw_mux_sel_o", exp_sel_i[7:4], act_sel_i[7:4]);
      compare_field("operand_c_fw_mux_sel_o", exp_sel_i[3:0], act_sel_i[3:0]);
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_core_controller.sv ====
// core controller testbench
// replays the stimulus file into the controller one line per clock cycle
// and hands the expected outputs of each line to the checker
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module tb_core_controller
  import ctrl_pkg::*;
();

  localparam int LINE_LEN     = 128;
  localparam int RESET_CYCLES = 3;
  localparam int SLACK_CYCLES = 20;

  logic    clk;
  logic    rst_n;

  // dut inputs, named as the ports
  logic    fetch_enable_i, illegal_insn_i, pipe_flush_i, instr_valid_i, id_ready_i;
  logic    ex_valid_i, data_req_ex_i, data_misaligned_i, branch_taken_ex_i, exc_req_i;
  logic    regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  jump_e   jump_in_dec_i;
  logic    reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i;
  logic    reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i;
  logic    reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i;

  // dut outputs
  logic    ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o;
  pc_mux_e pc_mux_o;
  logic    exc_ack_o, exc_save_if_o, exc_save_id_o, halt_if_o, halt_id_o;
  logic    deassert_we_o, load_stall_o, jr_stall_o, misaligned_stall_o;
  fw_sel_e operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o, operand_c_fw_mux_sel_o;

  // expected values of the line in flight
  logic                      check_en;
  logic [12:0]               exp_status;
  logic [`CTRL_PC_MUX_W-1:0] exp_pc_mux;
  logic [11:0]               exp_sel;

  // outputs packed in the same order as the file columns
  logic [12:0]               act_status;
  logic [11:0]               act_sel;

  int error_count;
  int check_count;
  int parse_errors = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;

  core_controller dut_i (.*);

  assign act_status = {ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o, exc_ack_o,
                       exc_save_if_o, exc_save_id_o, halt_if_o, halt_id_o, deassert_we_o,
                       load_stall_o, jr_stall_o, misaligned_stall_o};
  assign act_sel    = {2'b00, operand_a_fw_mux_sel_o, 2'b00, operand_b_fw_mux_sel_o,
                       2'b00, operand_c_fw_mux_sel_o};

  ctrl_checker ctrl_checker (
    .clk           (clk),
    .check_en_i    (check_en),
    .exp_status_i  (exp_status),
    .exp_pc_mux_i  (exp_pc_mux),
    .exp_sel_i     (exp_sel),
    .act_status_i  (act_status),
    .act_pc_mux_i  (pc_mux_o),
    .act_sel_i     (act_sel),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  // 100 ns period
  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  // blank lines and lines opening with # carry no stimulus
  function automatic bit skip_line(input logic [8*LINE_LEN-1:0] text);
    logic [7:0] ch;
    for (int i = LINE_LEN - 1; i >= 0; i--)
    begin
      ch = text[8*i +: 8];
      if (ch != 8'h00 && ch != " " && ch != "\t" && ch != "\n" && ch != "\r")
        return (ch == "#");
    end
    return 1'b1;
  endfunction

  // one file line becomes one cycle of inputs and expected outputs
  task automatic drive_line(input logic [9:0] ctrl_f, input logic [2:0] we_f,
                            input logic [1:0] jump_f, input logic [8:0] reg_f,
                            input logic [12:0] stat_f,
                            input logic [`CTRL_PC_MUX_W-1:0] pc_f,
                            input logic [11:0] sel_f);
    @(posedge clk);
    {fetch_enable_i, illegal_insn_i, pipe_flush_i, instr_valid_i, id_ready_i, ex_valid_i,
     data_req_ex_i, data_misaligned_i, branch_taken_ex_i, exc_req_i} <= ctrl_f;
    {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} <= we_f;
    jump_in_dec_i <= jump_e'(jump_f);
    {reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i,
     reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i,
     reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i} <= reg_f;
    exp_status <= stat_f;
    exp_pc_mux <= pc_f;
    exp_sel    <= sel_f;
    check_en   <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reset and stimulus replay
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin : stimulus_run
    int                        fd;
    int                        n;
    int                        line_no;
    int                        line_total;
    logic [8*LINE_LEN-1:0]     text;
    logic [9:0]                ctrl_f;
    logic [2:0]                we_f;
    logic [1:0]                jump_f;
    logic [8:0]                reg_f;
    logic [12:0]               stat_f;
    logic [`CTRL_PC_MUX_W-1:0] pc_f;
    logic [11:0]               sel_f;

    rst_n = 1'b0;
    {fetch_enable_i, illegal_insn_i, pipe_flush_i, instr_valid_i, id_ready_i, ex_valid_i,
     data_req_ex_i, data_misaligned_i, branch_taken_ex_i, exc_req_i} = '0;
    {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} = '0;
    jump_in_dec_i = BRANCH_NONE;
    {reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i,
     reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i,
     reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i} = '0;
    exp_status = '0;
    exp_pc_mux = '0;
    exp_sel    = '0;
    check_en   = 1'b0;
    line_total = 0;

    // first pass only counts lines, for the run limit
    fd = $fopen("verif/ctrl_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file verif/ctrl_stimulus.txt");
      $display("Checks failed");
      $finish;
    end
    else
    begin
      while (!$feof(fd))
      begin
        if ($fgets(text, fd) != 0)
          line_total++;
      end
      $fclose(fd);
      cycle_limit = line_total + SLACK_CYCLES;

      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      fd      = $fopen("verif/ctrl_stimulus.txt", "r");
      line_no = 0;
      while (!$feof(fd))
      begin
        text = '0;
        if ($fgets(text, fd) != 0)
        begin
          line_no++;
          if (!skip_line(text))
          begin
            n = $sscanf(text, "%b %b %h %b %b %h %h",
                        ctrl_f, we_f, jump_f, reg_f, stat_f, pc_f, sel_f);
            if (n != 7)
            begin
              $display("stimulus line %0d could not be parsed, %0d fields found",
                       line_no, n);
              parse_errors++;
            end
            else
              drive_line(ctrl_f, we_f, jump_f, reg_f, stat_f, pc_f, sel_f);
          end
        end
      end
      $fclose(fd);

      // let the checker see the last line
      @(posedge clk);
      check_en <= 1'b0;
      @(negedge clk);

      $display("checked %0d cycles: %0d mismatches, %0d unparsed lines",
               check_count, error_count, parse_errors);
      if (error_count == 0 && parse_errors == 0 && check_count > 0)
        $display("All checks passed");
      else
        $display("Checks failed");
      $finish;
    end
  end

  // run limit, counted from the end of reset
  initial
  begin
    forever
    begin
      @(posedge clk);
      if (rst_n)
        cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
      begin
        $display("timeout: stimulus still running after %0d cycles", cycle_limit);
        $display("Checks failed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/ctrl_stimulus.txt ====
# inputs: ctrl(fe ill flush ival idr exv dreq mis brt exc) we(ex wb alu) jump regs(ex wb alu abc)
# expected: status(busy dec req pcset ack sif sid hif hid dwe lst jrs mis) pc_mux sel(a b c)
# reset, boot and first fetch
0000000000 000 0 000000000 0000000001000 0 000
1000000000 000 0 000000000 0000000001000 0 000
1000000000 000 0 000000000 1011000001000 0 000
1000000000 000 0 000000000 1010000001000 0 000
1000000000 000 0 000000000 1010000001000 0 000
1000100000 000 0 000000000 1010000001000 0 000
1001100000 000 0 000000000 1110000000000 0 000
# forwarding priority and misaligned override
1001100000 010 0 000100000 1110000000000 0 200
1001100000 011 0 000011010 1110000000000 0 012
1001100100 011 0 000101010 1110000000001 0 102
# load-use stall, jalr stall, then jump latch
1001101000 100 0 010000000 1110000001100 0 000
1001000000 100 2 100000000 1110000001010 2 000
1001000000 100 2 100000000 1110000001010 2 000
1001000000 000 2 000000000 1111000000000 2 000
1001000000 000 2 000000000 1110000000000 2 000
1001100000 000 1 000000000 1110000000000 2 000
1001000000 000 1 000000000 1111000000000 2 000
1001000000 000 1 000000000 1110000000000 2 000
1001100000 000 0 000000000 1110000000000 0 000
# illegal instruction, taken branch, exception
1101100000 000 0 000000000 1110000001000 0 000
1001100011 000 0 000000000 1011000001000 3 000
1001100001 000 0 000000000 1111101010000 4 000
# flush to sleep, wake on exception
0011100000 000 0 000000000 1110000110000 0 000
0000000000 000 0 000000000 1010000111000 0 000
0000000000 000 0 000000000 1010000111000 0 000
0000010000 000 0 000000000 1010000111000 0 000
0000000000 000 0 000000000 1010000111000 0 000
0000000000 000 0 000000000 0000000111000 0 000
0000000001 000 0 000000000 0000000111000 0 000
0000000001 000 0 000000000 1011110001000 4 000
0000000000 000 0 000000000 1010000001000 0 000

// ==== flist.f ====
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/ctrl_fsm.sv
verilog/hazard_unit.sv
verilog/fwd_unit.sv
verilog/core_controller.sv
verif/ctrl_checker.sv
verif/tb_core_controller.sv

// ==== Bender.yml ====
package:
  name: core_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ctrl_pkg.sv
      - verilog/ctrl_fsm.sv
      - verilog/hazard_unit.sv
      - verilog/fwd_unit.sv
      - verilog/core_controller.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/ctrl_checker.sv
      - verif/tb_core_controller.sv
